//--- source/cpuIsaPkg.sv
package cpuIsaPkg;

    localparam int opcodeWidth   = 5;
    localparam int regFieldWidth = 4;
    localparam int constWidth    = 19;
    localparam int unusedWidth   = 15;

    // five bit opcodes with gaps in the numbering
    localparam logic [opcodeWidth-1:0] opLd     = 5'b00000;
    localparam logic [opcodeWidth-1:0] opLdi    = 5'b00001;
    localparam logic [opcodeWidth-1:0] opSt     = 5'b00010;
    localparam logic [opcodeWidth-1:0] opAdd    = 5'b00011;
    localparam logic [opcodeWidth-1:0] opSub    = 5'b00100;
    localparam logic [opcodeWidth-1:0] opAnd    = 5'b00101;
    localparam logic [opcodeWidth-1:0] opOr     = 5'b00110;
    localparam logic [opcodeWidth-1:0] opShr    = 5'b00111;
    localparam logic [opcodeWidth-1:0] opShl    = 5'b01001;
    localparam logic [opcodeWidth-1:0] opAddi   = 5'b01100;
    localparam logic [opcodeWidth-1:0] opAndi   = 5'b01101;
    localparam logic [opcodeWidth-1:0] opOri    = 5'b01110;
    localparam logic [opcodeWidth-1:0] opNeg    = 5'b10001;
    localparam logic [opcodeWidth-1:0] opNot    = 5'b10010;
    localparam logic [opcodeWidth-1:0] opBranch = 5'b10011;
    localparam logic [opcodeWidth-1:0] opIn     = 5'b10110;
    localparam logic [opcodeWidth-1:0] opOut    = 5'b10111;
    localparam logic [opcodeWidth-1:0] opNop    = 5'b11010;
    localparam logic [opcodeWidth-1:0] opHalt   = 5'b11011;

    // branch condition in rb[1:0]
    localparam logic [1:0] condZero    = 2'b00;
    localparam logic [1:0] condNonZero = 2'b01;

    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0]   opcode;
            logic [regFieldWidth-1:0] ra;
            logic [regFieldWidth-1:0] rb;
            logic [regFieldWidth-1:0] rc;
            logic [unusedWidth-1:0]   unused;
        } regForm;
        struct packed {
            logic [opcodeWidth-1:0]   opcode;
            logic [regFieldWidth-1:0] ra;
            logic [regFieldWidth-1:0] rb;
            logic [constWidth-1:0]    constant;
        } immForm;
    } instrWord;

endpackage

//--- source/cpuBusPkg.sv
package cpuBusPkg;

    // width of the internal bus and of every datapath register
    localparam int dataWidth = 32;

    // general purpose registers with R0 as the zero base
    localparam int regCount = 16;

    // RAM address width for 512 words
    localparam int memAddrWidth = 9;

endpackage

//--- source/ctrlBus.sv
`timescale 1ns/1ns

interface ctrlBus (
    input logic clk
);
    // in strobes
    logic pcIn, incPc, marIn, mdrIn, irIn, yIn, zIn, conIn, rIn, outPortIn;
    // out strobes that are one-hot or all low
    logic pcOut, zLowOut, mdrOut, rOut, baOut, cOut, inPortOut;
    logic gra, grb, grc;           // register field selects
    logic memRead, memWrite;
    cpuIsaPkg::instrWord ir;
    logic con;                     // branch condition from the execute unit

    modport seq (
        input  clk, con,
        output pcIn, incPc, marIn, mdrIn, irIn, yIn, zIn, conIn, rIn, outPortIn,
        output pcOut, zLowOut, mdrOut, rOut, baOut, cOut, inPortOut,
        output gra, grb, grc, memRead, memWrite, ir
    );

    modport dp (
        input  clk,
        input  pcIn, incPc, marIn, mdrIn, irIn, yIn, zIn, conIn, rIn, outPortIn,
        input  pcOut, zLowOut, mdrOut, rOut, baOut, cOut, inPortOut,
        input  gra, grb, grc, memRead, memWrite, ir,
        output con
    );

    modport arb (
        input clk, pcOut, zLowOut, mdrOut, rOut, baOut, cOut, inPortOut, ir
    );
endinterface

//--- source/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer (
    input  logic                              clk,
    input  logic                              clr,
    input  logic                              stop,
    ctrlBus.seq                               ctl,
    input  logic [cpuBusPkg::dataWidth-1:0]   bus,
    output logic                              run
);

    localparam logic [5:0]
        stIdle  = 6'd0,  stT0    = 6'd1,  stT1    = 6'd2,  stT2    = 6'd3,
        stAT3   = 6'd4,  stAT4   = 6'd5,  stAT5   = 6'd6,
        stIT3   = 6'd7,  stIT4   = 6'd8,  stIT5   = 6'd9,
        stNT3   = 6'd10, stNT4   = 6'd11,
        stLdT3  = 6'd12, stLdT4  = 6'd13, stLdT5  = 6'd14, stLdT6  = 6'd15, stLdT7 = 6'd16,
        stLdiT3 = 6'd17, stLdiT4 = 6'd18, stLdiT5 = 6'd19,
        stStT3  = 6'd20, stStT4  = 6'd21, stStT5  = 6'd22, stStT6  = 6'd23, stStT7 = 6'd24,
        stBrT3  = 6'd25, stBrT4  = 6'd26, stBrT5  = 6'd27, stBrT6  = 6'd28,
        stInT3  = 6'd29, stOutT3 = 6'd30, stNopT3 = 6'd31, stHalt  = 6'd32;

    logic [5:0] state;
    logic [5:0] nextState;
    cpuIsaPkg::instrWord fetched;

    // in T2 the new instruction is on the bus while IR loads
    assign fetched = bus;

    always_ff @(posedge clk) begin
        if (ctl.irIn)
            ctl.ir <= bus;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr)
            state <= stIdle;
        else if (stop)
            state <= stHalt;
        else
            state <= nextState;
    end

    always_comb begin
        case (state)
            stIdle:  nextState = stT0;
            stT0:    nextState = stT1;
            stT1:    nextState = stT2;
            stT2: begin
                case (fetched.regForm.opcode)
                    cpuIsaPkg::opAdd, cpuIsaPkg::opSub, cpuIsaPkg::opAnd, cpuIsaPkg::opOr,
                    cpuIsaPkg::opShl, cpuIsaPkg::opShr:    nextState = stAT3;
                    cpuIsaPkg::opAddi, cpuIsaPkg::opAndi,
                    cpuIsaPkg::opOri:                      nextState = stIT3;
                    cpuIsaPkg::opNeg, cpuIsaPkg::opNot:    nextState = stNT3;
                    cpuIsaPkg::opLd:                       nextState = stLdT3;
                    cpuIsaPkg::opLdi:                      nextState = stLdiT3;
                    cpuIsaPkg::opSt:                       nextState = stStT3;
                    cpuIsaPkg::opBranch:                   nextState = stBrT3;
                    cpuIsaPkg::opIn:                       nextState = stInT3;
                    cpuIsaPkg::opOut:                      nextState = stOutT3;
                    cpuIsaPkg::opNop:                      nextState = stNopT3;
                    cpuIsaPkg::opHalt:                     nextState = stHalt;
                    default:                               nextState = stT0;
                endcase
            end
            stAT3:   nextState = stAT4;
            stAT4:   nextState = stAT5;
            stIT3:   nextState = stIT4;
            stIT4:   nextState = stIT5;
            stNT3:   nextState = stNT4;
            stLdT3:  nextState = stLdT4;
            stLdT4:  nextState = stLdT5;
            stLdT5:  nextState = stLdT6;
            stLdT6:  nextState = stLdT7;
            stLdiT3: nextState = stLdiT4;
            stLdiT4: nextState = stLdiT5;
            stStT3:  nextState = stStT4;
            stStT4:  nextState = stStT5;
            stStT5:  nextState = stStT6;
            stStT6:  nextState = stStT7;
            stBrT3:  nextState = stBrT4;
            stBrT4:  nextState = stBrT5;
            stBrT5:  nextState = stBrT6;
            stHalt:  nextState = stHalt;     // held until clr
            default: nextState = stT0;       // last step of every instruction
        endcase
    end

    // strobes decoded from the state with none in idle
    assign ctl.pcOut     = state inside {stT0, stBrT4};
    assign ctl.marIn     = state inside {stT0, stLdT5, stStT5};
    assign ctl.incPc     = state == stT0;
    assign ctl.memRead   = state inside {stT1, stLdT6};
    assign ctl.mdrIn     = state inside {stT1, stLdT6, stStT6};
    assign ctl.mdrOut    = state inside {stT2, stLdT7};
    assign ctl.irIn      = state == stT2;
    assign ctl.gra       = state inside {stAT5, stIT5, stNT4, stLdT7, stLdiT5, stStT6,
                                         stBrT3, stInT3, stOutT3};
    assign ctl.grb       = state inside {stAT3, stIT3, stNT3, stLdT3, stLdiT3, stStT3};
    assign ctl.grc       = state == stAT4;
    assign ctl.rOut      = state inside {stAT3, stAT4, stIT3, stNT3, stStT6, stBrT3, stOutT3};
    assign ctl.baOut     = state inside {stLdT3, stLdiT3, stStT3};
    assign ctl.rIn       = state inside {stAT5, stIT5, stNT4, stLdT7, stLdiT5, stInT3};
    assign ctl.yIn       = state inside {stAT3, stIT3, stLdT3, stLdiT3, stStT3, stBrT4};
    assign ctl.zIn       = state inside {stAT4, stIT4, stNT3, stLdT4, stLdiT4, stStT4, stBrT5};
    assign ctl.zLowOut   = state inside {stAT5, stIT5, stNT4, stLdT5, stLdiT5, stStT5, stBrT6};
    assign ctl.cOut      = state inside {stIT4, stLdT4, stLdiT4, stStT4, stBrT5};
    assign ctl.conIn     = state == stBrT3;
    assign ctl.pcIn      = state == stBrT6;    // gated by con in the execute unit
    assign ctl.inPortOut = state == stInT3;
    assign ctl.outPortIn = state == stOutT3;
    assign ctl.memWrite  = state == stStT7;

    // run drops one cycle after halt is reached
    always_ff @(posedge clk or posedge clr) begin
        if (clr)
            run <= 1'b1;
        else if (state == stHalt)
            run <= 1'b0;
    end

    // a register write never overlaps a RAM write
    assert property (@(posedge clk) disable iff (clr) !(ctl.rIn && ctl.memWrite));

endmodule

//--- source/busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
    ctrlBus.arb                               ctl,
    input  logic [cpuBusPkg::dataWidth-1:0]   regData,
    input  logic [cpuBusPkg::dataWidth-1:0]   zLow,
    input  logic [cpuBusPkg::dataWidth-1:0]   mdrData,
    input  logic [cpuBusPkg::dataWidth-1:0]   pcData,
    input  logic [cpuBusPkg::dataWidth-1:0]   inPort,
    output logic [cpuBusPkg::dataWidth-1:0]   bus
);

    logic [cpuBusPkg::dataWidth-1:0] constExt;
    logic [cpuIsaPkg::constWidth-1:0] constField;

    assign constField = ctl.ir.immForm.constant;
    assign constExt = {
        {(cpuBusPkg::dataWidth - cpuIsaPkg::constWidth){constField[cpuIsaPkg::constWidth-1]}},
        constField
    };

    always_comb begin
        if (ctl.rOut || ctl.baOut)
            bus = regData;
        else if (ctl.zLowOut)
            bus = zLow;
        else if (ctl.mdrOut)
            bus = mdrData;
        else if (ctl.pcOut)
            bus = pcData;
        else if (ctl.cOut)
            bus = constExt;
        else if (ctl.inPortOut)
            bus = inPort;
        else
            bus = '0;     // idle bus
    end

    // the sequencer never lets two sources drive at once
    assert property (@(posedge ctl.clk)
        $onehot0({ctl.rOut, ctl.baOut, ctl.zLowOut, ctl.mdrOut, ctl.pcOut, ctl.cOut,
                  ctl.inPortOut}));

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                              clk,
    input  logic                              clr,
    ctrlBus.dp                                ctl,
    input  logic [cpuBusPkg::dataWidth-1:0]   bus,
    output logic [cpuBusPkg::dataWidth-1:0]   regData
);

    logic [cpuBusPkg::dataWidth-1:0] regs [cpuBusPkg::regCount];
    logic [cpuIsaPkg::regFieldWidth-1:0] idx;

    // field select picks which IR field names the register
    always_comb begin
        if (ctl.gra)
            idx = ctl.ir.regForm.ra;
        else if (ctl.grb)
            idx = ctl.ir.regForm.rb;
        else if (ctl.grc)
            idx = ctl.ir.regForm.rc;
        else
            idx = '0;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            for (int i = 0; i < cpuBusPkg::regCount; i++)
                regs[i] <= '0;
        end else if (ctl.rIn) begin
            regs[idx] <= bus;
        end
    end

    always_comb begin
        if (ctl.baOut && idx == '0)
            regData = '0;         // zero base for absolute addressing
        else if (ctl.rOut || ctl.baOut)
            regData = regs[idx];
        else
            regData = '0;
    end

endmodule

//--- source/execUnit.sv
`timescale 1ns/1ns

module execUnit #(
    parameter logic [cpuBusPkg::dataWidth-1:0] resetPc = '0
) (
    input  logic                              clk,
    input  logic                              clr,
    ctrlBus.dp                                ctl,
    input  logic [cpuBusPkg::dataWidth-1:0]   bus,
    output logic [cpuBusPkg::dataWidth-1:0]   zLow,
    output logic [cpuBusPkg::dataWidth-1:0]   pcData
);

    logic [cpuBusPkg::dataWidth-1:0] y;
    logic [cpuBusPkg::dataWidth-1:0] z;
    logic [cpuBusPkg::dataWidth-1:0] aluOut;
    logic [cpuBusPkg::dataWidth-1:0] pc;
    logic isBranch;

    assign isBranch = ctl.ir.regForm.opcode == cpuIsaPkg::opBranch;

    always_comb begin
        case (ctl.ir.regForm.opcode)
            cpuIsaPkg::opSub:                     aluOut = y - bus;
            cpuIsaPkg::opAnd, cpuIsaPkg::opAndi:  aluOut = y & bus;
            cpuIsaPkg::opOr, cpuIsaPkg::opOri:    aluOut = y | bus;
            cpuIsaPkg::opShl:                     aluOut = y << bus[4:0];
            cpuIsaPkg::opShr:                     aluOut = y >> bus[4:0];
            cpuIsaPkg::opNeg:                     aluOut = -bus;    // Y not involved
            cpuIsaPkg::opNot:                     aluOut = ~bus;
            default:                              aluOut = y + bus; // address and offset sums too
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctl.yIn)
            y <= bus;
        if (ctl.zIn)
            z <= aluOut;
    end

    // a branch target only lands when the condition held
    always_ff @(posedge clk or posedge clr) begin
        if (clr)
            pc <= resetPc;
        else if (ctl.pcIn && (!isBranch || ctl.con))
            pc <= bus;
        else if (ctl.incPc)
            pc <= pc + 1'b1;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            ctl.con <= 1'b0;
        end else if (ctl.conIn) begin
            case (ctl.ir.immForm.rb[1:0])
                cpuIsaPkg::condZero:    ctl.con <= bus == '0;
                cpuIsaPkg::condNonZero: ctl.con <= bus != '0;
                default:                ctl.con <= 1'b0;   // brpl/brmi not built
            endcase
        end
    end

    assign zLow = z;
    assign pcData = pc;

endmodule

//--- source/memoryPort.sv
`timescale 1ns/1ns

module memoryPort #(
    parameter int memDepth = 512
) (
    input  logic                                 clk,
    input  logic                                 clr,
    ctrlBus.dp                                   ctl,
    input  logic [cpuBusPkg::dataWidth-1:0]      bus,
    input  logic                                 loadEn,
    input  logic [cpuBusPkg::memAddrWidth-1:0]   loadAddr,
    input  logic [cpuBusPkg::dataWidth-1:0]      loadData,
    output logic [cpuBusPkg::dataWidth-1:0]      mdrData,
    output logic [cpuBusPkg::dataWidth-1:0]      outPort,
    output logic                                 outValid
);

    logic [cpuBusPkg::dataWidth-1:0] ram [memDepth];
    logic [cpuBusPkg::memAddrWidth-1:0] mar;
    logic [cpuBusPkg::dataWidth-1:0] mdr;

    always_ff @(posedge clk) begin
        if (ctl.marIn)
            mar <= bus[cpuBusPkg::memAddrWidth-1:0];
        if (ctl.mdrIn)
            mdr <= ctl.memRead ? ram[mar] : bus;
        // the load port wins over a CPU write
        if (loadEn)
            ram[loadAddr] <= loadData;
        else if (ctl.memWrite)
            ram[mar] <= mdr;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            outPort <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= ctl.outPortIn;     // single cycle pulse
            if (ctl.outPortIn)
                outPort <= bus;
        end
    end

    assign mdrData = mdr;

    // effective addresses from Z must fall inside the RAM
    assert property (@(posedge clk) disable iff (clr) ctl.memRead |-> mar < memDepth);

endmodule

//--- source/cpuTop.sv
`timescale 1ns/1ns

module cpuTop #(
    parameter int                              memDepth = 512,
    parameter logic [cpuBusPkg::dataWidth-1:0] resetPc  = '0
) (
    input  logic                                 clk,
    input  logic                                 clr,
    input  logic                                 stop,
    input  logic [cpuBusPkg::dataWidth-1:0]      inPort,
    input  logic                                 loadEn,
    input  logic [cpuBusPkg::memAddrWidth-1:0]   loadAddr,
    input  logic [cpuBusPkg::dataWidth-1:0]      loadData,
    output logic [cpuBusPkg::dataWidth-1:0]      outPort,
    output logic                                 outValid,
    output logic                                 run
);

    logic [cpuBusPkg::dataWidth-1:0] bus;      // shared internal bus
    logic [cpuBusPkg::dataWidth-1:0] regData;
    logic [cpuBusPkg::dataWidth-1:0] zLow;
    logic [cpuBusPkg::dataWidth-1:0] mdrData;
    logic [cpuBusPkg::dataWidth-1:0] pcData;

    ctrlBus ctl (.clk(clk));

    controlSequencer uSeq (
        .clk(clk), .clr(clr), .stop(stop), .ctl(ctl.seq), .bus(bus), .run(run)
    );

    busArbiter uArb (
        .ctl(ctl.arb), .regData(regData), .zLow(zLow), .mdrData(mdrData),
        .pcData(pcData), .inPort(inPort), .bus(bus)
    );

    registerFile uRegs (
        .clk(clk), .clr(clr), .ctl(ctl.dp), .bus(bus), .regData(regData)
    );

    execUnit #(.resetPc(resetPc)) uExec (
        .clk(clk), .clr(clr), .ctl(ctl.dp), .bus(bus), .zLow(zLow), .pcData(pcData)
    );

    memoryPort #(.memDepth(memDepth)) uMem (
        .clk(clk), .clr(clr), .ctl(ctl.dp), .bus(bus),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .mdrData(mdrData), .outPort(outPort), .outValid(outValid)
    );

endmodule

//--- bench/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

    localparam int rowCount  = 19;
    localparam int waitLimit = 300;   // cycles per wait

    // case kinds
    localparam int kindAlu       = 0;
    localparam int kindMem       = 1;
    localparam int kindMemZero   = 2;
    localparam int kindBrTaken   = 3;
    localparam int kindBrNoTaken = 4;
    localparam int kindInput     = 5;

    logic        clk;
    logic        clr;
    logic        stop;
    logic [31:0] inPort;
    logic        loadEn;
    logic [8:0]  loadAddr;
    logic [31:0] loadData;
    logic [31:0] outPort;
    logic        outValid;
    logic        run;

    // stimulus and expected values with one row per case
    logic [4:0]  opTab   [rowCount];
    int          kindTab [rowCount];
    logic [1:0]  condTab [rowCount];
    logic [31:0] aTab    [rowCount];
    logic [31:0] bTab    [rowCount];
    logic [31:0] expTab  [rowCount];

    logic [8:0]  imgAddr [$];        // RAM image for the current row
    logic [31:0] imgData [$];
    logic [31:0] lfsrState;

    cpuTop DUT (
        .clk(clk), .clr(clr), .stop(stop), .inPort(inPort),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .outPort(outPort), .outValid(outValid), .run(run)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
            failRun($sformatf("mismatch at time %0t: %s got %h expected %h",
                              $time, what, actual, expected));
    endtask

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic takeBits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = galoisStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] signExtend19(input logic [18:0] v);
        return {{13{v[18]}}, v};
    endfunction

    function automatic logic [31:0] regInstr(input logic [4:0] op, input logic [3:0] ra,
                                             input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] immInstr(input logic [4:0] op, input logic [3:0] ra,
                                             input logic [3:0] rb, input logic [31:0] c);
        return {op, ra, rb, c[18:0]};
    endfunction

    task automatic setRow(input int r, input logic [4:0] op, input int kind,
                          input logic [1:0] cond);
        logic [31:0] raw;
        logic [31:0] a;
        logic [31:0] b;
        takeBits(19, raw);
        a = signExtend19(raw[18:0]);
        takeBits(19, raw);
        b = signExtend19(raw[18:0]);
        if (kind == kindMem || kind == kindMemZero) begin
            takeBits(8, raw);
            b = 32'd64 + raw;            // data word well past the program
        end else if (kind == kindInput) begin
            takeBits(32, a);
        end
        opTab[r] = op;
        kindTab[r] = kind;
        condTab[r] = cond;
        aTab[r] = a;
        bTab[r] = b;
        case (kind)
            kindAlu: begin
                case (op)
                    cpuIsaPkg::opAdd, cpuIsaPkg::opAddi: expTab[r] = a + b;
                    cpuIsaPkg::opSub:                    expTab[r] = a - b;
                    cpuIsaPkg::opAnd, cpuIsaPkg::opAndi: expTab[r] = a & b;
                    cpuIsaPkg::opOr, cpuIsaPkg::opOri:   expTab[r] = a | b;
                    cpuIsaPkg::opShl:                    expTab[r] = a << b[4:0];
                    cpuIsaPkg::opShr:                    expTab[r] = a >> b[4:0];
                    cpuIsaPkg::opNeg:                    expTab[r] = -a;
                    cpuIsaPkg::opNot:                    expTab[r] = ~a;
                    default:                             expTab[r] = a;   // nop
                endcase
            end
            kindBrTaken: expTab[r] = b;     // out r1 skipped
            default:     expTab[r] = a;
        endcase
    endtask

    task automatic putWord(input logic [8:0] addr, input logic [31:0] data);
        imgAddr.push_back(addr);
        imgData.push_back(data);
    endtask

    task automatic buildImage(input int r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        logic [31:0] testVal;
        logic [4:0] op;
        a = aTab[r];
        b = bTab[r];
        op = opTab[r];
        imgAddr.delete();
        imgData.delete();
        case (kindTab[r])
            kindAlu: begin
                putWord(0, immInstr(cpuIsaPkg::opLdi, 1, 0, a));
                if (op inside {cpuIsaPkg::opAddi, cpuIsaPkg::opAndi, cpuIsaPkg::opOri}) begin
                    putWord(1, immInstr(op, 3, 1, b));
                    putWord(2, immInstr(cpuIsaPkg::opOut, 3, 0, 0));
                end else if (op inside {cpuIsaPkg::opNeg, cpuIsaPkg::opNot}) begin
                    putWord(1, regInstr(op, 3, 1, 0));
                    putWord(2, immInstr(cpuIsaPkg::opOut, 3, 0, 0));
                end else if (op == cpuIsaPkg::opNop) begin
                    putWord(1, regInstr(op, 0, 0, 0));
                    putWord(2, immInstr(cpuIsaPkg::opOut, 1, 0, 0));
                end else begin
                    putWord(1, immInstr(cpuIsaPkg::opLdi, 2, 0, b));
                    putWord(2, regInstr(op, 3, 1, 2));
                    putWord(3, immInstr(cpuIsaPkg::opOut, 3, 0, 0));
                end
                putWord(imgAddr.size(), regInstr(cpuIsaPkg::opHalt, 0, 0, 0));
            end
            kindMem, kindMemZero: begin
                base = {b[31:4], 4'd0};
                putWord(0, immInstr(cpuIsaPkg::opLdi, 1, 0, a));
                if (kindTab[r] == kindMem) begin
                    putWord(1, immInstr(cpuIsaPkg::opLdi, 6, 0, base));
                    putWord(2, immInstr(cpuIsaPkg::opSt, 1, 6, b - base));
                    putWord(3, immInstr(cpuIsaPkg::opLd, 4, 6, b - base));
                end else begin
                    // junk in r0 must not move the store while r7 still reads zero
                    putWord(1, immInstr(cpuIsaPkg::opLdi, 0, 0, 8));
                    putWord(2, immInstr(cpuIsaPkg::opSt, 1, 0, b));
                    putWord(3, immInstr(cpuIsaPkg::opLd, 4, 7, b));
                end
                putWord(4, immInstr(cpuIsaPkg::opOut, 4, 0, 0));
                putWord(5, regInstr(cpuIsaPkg::opHalt, 0, 0, 0));
                putWord(b[8:0], ~a);            // stale word the load must not see
            end
            kindBrTaken, kindBrNoTaken: begin
                if ((condTab[r] == cpuIsaPkg::condZero) == (kindTab[r] == kindBrTaken))
                    testVal = '0;
                else
                    testVal = a | 32'd1;
                putWord(0, immInstr(cpuIsaPkg::opLdi, 1, 0, a));
                putWord(1, immInstr(cpuIsaPkg::opLdi, 2, 0, b));
                putWord(2, immInstr(cpuIsaPkg::opLdi, 3, 0, testVal));
                putWord(3, immInstr(cpuIsaPkg::opBranch, 3, {2'b00, condTab[r]}, 1));
                putWord(4, immInstr(cpuIsaPkg::opOut, 1, 0, 0));
                putWord(5, immInstr(cpuIsaPkg::opOut, 2, 0, 0));
                putWord(6, regInstr(cpuIsaPkg::opHalt, 0, 0, 0));
            end
            default: begin
                putWord(0, immInstr(cpuIsaPkg::opIn, 5, 0, 0));
                putWord(1, immInstr(cpuIsaPkg::opOut, 5, 0, 0));
                putWord(2, regInstr(cpuIsaPkg::opHalt, 0, 0, 0));
            end
        endcase
    endtask

    // program goes in through the load port while clr holds the CPU
    task automatic loadAndReset(input int r);
        int i;
        @(posedge clk);
        clr <= 1'b1;
        inPort <= aTab[r];
        for (i = 0; i < imgAddr.size(); i++) begin
            @(posedge clk);
            loadEn <= 1'b1;
            loadAddr <= imgAddr[i];
            loadData <= imgData[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        repeat (4) @(posedge clk);
        clr <= 1'b0;
    endtask

    task automatic waitOutValid(input int r);
        int n;
        n = 0;
        while (!outValid && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!outValid)
            failRun($sformatf("timeout: no outValid within %0d cycles in row %0d",
                              waitLimit, r));
    endtask

    task automatic waitRunLow(input int r);
        int n;
        n = 0;
        while (run && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (run)
            failRun($sformatf("timeout: run stayed high for %0d cycles in row %0d",
                              waitLimit, r));
    endtask

    // halted CPU stays silent
    task automatic checkQuiet(input int r);
        repeat (20) begin
            @(negedge clk);
            checkValue({31'd0, outValid}, 32'd0, $sformatf("row %0d outValid after halt", r));
            checkValue({31'd0, run}, 32'd0, $sformatf("row %0d run after halt", r));
        end
    endtask

    initial begin
        int r;
        clr = 1'b1;
        stop = 1'b0;
        inPort = '0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lfsrState = 32'd86836;

        setRow(0,  cpuIsaPkg::opAdd,    kindAlu,       2'b00);
        setRow(1,  cpuIsaPkg::opSub,    kindAlu,       2'b00);
        setRow(2,  cpuIsaPkg::opAnd,    kindAlu,       2'b00);
        setRow(3,  cpuIsaPkg::opOr,     kindAlu,       2'b00);
        setRow(4,  cpuIsaPkg::opShl,    kindAlu,       2'b00);
        setRow(5,  cpuIsaPkg::opShr,    kindAlu,       2'b00);
        setRow(6,  cpuIsaPkg::opAddi,   kindAlu,       2'b00);
        setRow(7,  cpuIsaPkg::opAndi,   kindAlu,       2'b00);
        setRow(8,  cpuIsaPkg::opOri,    kindAlu,       2'b00);
        setRow(9,  cpuIsaPkg::opNeg,    kindAlu,       2'b00);
        setRow(10, cpuIsaPkg::opNot,    kindAlu,       2'b00);
        setRow(11, cpuIsaPkg::opNop,    kindAlu,       2'b00);
        setRow(12, cpuIsaPkg::opSt,     kindMem,       2'b00);
        setRow(13, cpuIsaPkg::opSt,     kindMemZero,   2'b00);
        setRow(14, cpuIsaPkg::opBranch, kindBrTaken,   cpuIsaPkg::condZero);
        setRow(15, cpuIsaPkg::opBranch, kindBrTaken,   cpuIsaPkg::condNonZero);
        setRow(16, cpuIsaPkg::opBranch, kindBrNoTaken, cpuIsaPkg::condZero);
        setRow(17, cpuIsaPkg::opBranch, kindBrNoTaken, cpuIsaPkg::condNonZero);
        setRow(18, cpuIsaPkg::opIn,     kindInput,     2'b00);

        for (r = 0; r < rowCount; r++) begin
            buildImage(r);
            loadAndReset(r);
            waitOutValid(r);
            checkValue(outPort, expTab[r], $sformatf("row %0d first output", r));
            waitRunLow(r);
            checkQuiet(r);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- project.f
source/cpuIsaPkg.sv
source/cpuBusPkg.sv
source/ctrlBus.sv
source/controlSequencer.sv
source/busArbiter.sv
source/registerFile.sv
source/execUnit.sv
source/memoryPort.sv
source/cpuTop.sv
bench/cpuTb.sv

//--- Bender.yml
package:
  name: single_bus_cpu

sources:
  - files:
      - source/cpuIsaPkg.sv
      - source/cpuBusPkg.sv
      - source/ctrlBus.sv
      - source/controlSequencer.sv
      - source/busArbiter.sv
      - source/registerFile.sv
      - source/execUnit.sv
      - source/memoryPort.sv
      - source/cpuTop.sv
  - target: test
    files:
      - bench/cpuTb.sv
